/* Makefile */
TOP = tb_soc_bus_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* all.f */
rtl/soc_bus_pkg.sv
rtl/int_sram.sv
rtl/periph_regs.sv
rtl/data_bus_split.sv
rtl/sram_arbiter.sv
rtl/soc_bus_top.sv
sim/tb_soc_bus_top.sv

/* rtl/data_bus_split.sv */
`timescale 1ns/1ps

module data_bus_split (
   input  logic                clk_i,
   input  logic                rst_i,
   // data master
   input  logic                m_req_valid_i,
   input  soc_bus_pkg::addr_t  m_addr_i,
   input  soc_bus_pkg::data_t  m_wdata_i,
   input  soc_bus_pkg::strb_t  m_wstrb_i,
   output logic                m_req_ready_o,
   output logic                m_rsp_valid_o,
   output soc_bus_pkg::data_t  m_rdata_o,
   // sram side
   output logic                mem_req_valid_o,
   output soc_bus_pkg::addr_t  mem_addr_o,
   output soc_bus_pkg::data_t  mem_wdata_o,
   output soc_bus_pkg::strb_t  mem_wstrb_o,
   input  logic                mem_req_ready_i,
   input  logic                mem_rsp_valid_i,
   input  soc_bus_pkg::data_t  mem_rdata_i,
   // peripheral side
   output logic                per_req_valid_o,
   output soc_bus_pkg::addr_t  per_addr_o,
   output soc_bus_pkg::data_t  per_wdata_o,
   output soc_bus_pkg::strb_t  per_wstrb_o,
   input  logic                per_req_ready_i,
   input  logic                per_rsp_valid_i,
   input  soc_bus_pkg::data_t  per_rdata_i
);
   import soc_bus_pkg::*;

   logic sel_per;
   logic acc;
   logic rsp;
   logic pend_q;
   logic pend_per_q;

   assign sel_per = m_addr_i[PERIPH_SEL_BIT];

   // request goes to one side only, and only with nothing outstanding
   assign mem_req_valid_o = m_req_valid_i & ~pend_q & ~sel_per;
   assign per_req_valid_o = m_req_valid_i & ~pend_q & sel_per;

   assign mem_addr_o  = m_addr_i;
   assign mem_wdata_o = m_wdata_i;
   assign mem_wstrb_o = m_wstrb_i;
   assign per_addr_o  = m_addr_i;
   assign per_wdata_o = m_wdata_i;
   assign per_wstrb_o = m_wstrb_i;

   assign m_req_ready_o = ~pend_q & (sel_per ? per_req_ready_i : mem_req_ready_i);
   assign acc           = m_req_valid_i & m_req_ready_o;

   // response steered from the side that holds the access
   assign rsp           = pend_per_q ? per_rsp_valid_i : mem_rsp_valid_i;
   assign m_rsp_valid_o = pend_q & rsp;
   assign m_rdata_o     = pend_per_q ? per_rdata_i : mem_rdata_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pend_q     <= 1'b0;
         pend_per_q <= 1'b0;
      end else if (acc) begin
         pend_q     <= 1'b1;
         pend_per_q <= sel_per;
      end else if (m_rsp_valid_o) begin
         pend_q     <= 1'b0;
      end
   end

   // a slave may only answer the access it was given
   a_per_rsp_owned: assert property (
      @(posedge clk_i) disable iff (rst_i) per_rsp_valid_i |-> pend_q && pend_per_q);
   a_mem_rsp_owned: assert property (
      @(posedge clk_i) disable iff (rst_i) mem_rsp_valid_i |-> pend_q && !pend_per_q);

endmodule

/* rtl/int_sram.sv */
`timescale 1ns/1ps

module int_sram (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    req_valid_i,
   input  soc_bus_pkg::sram_idx_t  idx_i,
   input  soc_bus_pkg::data_t      wdata_i,
   input  soc_bus_pkg::strb_t      wstrb_i,
   output logic                    rsp_valid_o,
   output soc_bus_pkg::data_t      rdata_o
);
   import soc_bus_pkg::*;

   data_t mem [SRAM_WORDS];

   // no ready output, every request is taken the cycle it shows up

   // per-byte write lanes
   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) begin
               mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   // read data registered, old contents on a write
   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         rdata_o <= mem[idx_i];
      end
   end

   // response one cycle after the request
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= req_valid_i;
      end
   end

endmodule

/* rtl/periph_regs.sv */
`timescale 1ns/1ps

module periph_regs (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                req_valid_i,
   input  soc_bus_pkg::addr_t  addr_i,
   input  soc_bus_pkg::data_t  wdata_i,
   input  soc_bus_pkg::strb_t  wstrb_i,
   output logic                req_ready_o,
   output logic                rsp_valid_o,
   output soc_bus_pkg::data_t  rdata_o,
   output soc_bus_pkg::data_t  gpio_o
);
   import soc_bus_pkg::*;

   logic      live_q;
   logic      acc;
   logic      wr;
   per_offs_t offs;
   data_t     gpio_q;
   data_t     scratch_q;
   data_t     rd_mux;

   // replace only the strobed bytes
   function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
      data_t res;
      res = old_val;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign req_ready_o = live_q;
   assign acc         = req_valid_i & live_q;
   assign wr          = acc & (|wstrb_i);
   assign offs        = addr_i[PERIPH_SEL_BIT-1:WORD_LSB];
   assign gpio_o      = gpio_q;

   // unmapped offsets read zero
   always_comb begin
      case (offs)
         GPIO_OFFS:    rd_mux = gpio_q;
         SCRATCH_OFFS: rd_mux = scratch_q;
         ID_OFFS:      rd_mux = PERIPH_ID;
         default:      rd_mux = '0;
      endcase
   end

   // ID word has no write path
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         live_q      <= 1'b0;
         rsp_valid_o <= 1'b0;
         gpio_q      <= '0;
         scratch_q   <= '0;
      end else begin
         live_q      <= 1'b1;
         rsp_valid_o <= acc;
         if (wr && offs == GPIO_OFFS) begin
            gpio_q <= merge_bytes(gpio_q, wdata_i, wstrb_i);
         end
         if (wr && offs == SCRATCH_OFFS) begin
            scratch_q <= merge_bytes(scratch_q, wdata_i, wstrb_i);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (acc) begin
         rdata_o <= rd_mux;
      end
   end

   // the split must hold off a second request until this one answers
   a_no_back_to_back_rsp: assert property (
      @(posedge clk_i) disable iff (rst_i) rsp_valid_o |=> !rsp_valid_o);

endmodule

/* rtl/soc_bus_pkg.sv */
package soc_bus_pkg;

   // bus widths
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 32;
   localparam int STRB_W      = DATA_W / 8;
   localparam int WORD_LSB    = $clog2(STRB_W);

   // internal sram size
   localparam int SRAM_ADDR_W = 10;
   localparam int SRAM_WORDS  = 1 << SRAM_ADDR_W;

   // bit 15 set means peripheral space
   localparam int PERIPH_SEL_BIT = 15;

   typedef logic [ADDR_W-1:0]      addr_t;
   typedef logic [DATA_W-1:0]      data_t;
   // all zeros is a read
   typedef logic [STRB_W-1:0]      strb_t;
   typedef logic [SRAM_ADDR_W-1:0] sram_idx_t;

   // word offset inside the peripheral space
   typedef logic [PERIPH_SEL_BIT-WORD_LSB-1:0] per_offs_t;

   // peripheral register map, word offsets
   localparam per_offs_t GPIO_OFFS    = 'd0;
   localparam per_offs_t SCRATCH_OFFS = 'd1;
   localparam per_offs_t ID_OFFS      = 'd2;

   localparam data_t PERIPH_ID = 32'h50c0_0001;

endpackage

/* rtl/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top (
   input  logic                clk_i,
   input  logic                rst_i,
   // instruction port
   input  logic                ibus_req_valid_i,
   input  soc_bus_pkg::addr_t  ibus_addr_i,
   output logic                ibus_req_ready_o,
   output logic                ibus_rsp_valid_o,
   output soc_bus_pkg::data_t  ibus_rdata_o,
   // data port
   input  logic                dbus_req_valid_i,
   input  soc_bus_pkg::addr_t  dbus_addr_i,
   input  soc_bus_pkg::data_t  dbus_wdata_i,
   input  soc_bus_pkg::strb_t  dbus_wstrb_i,
   output logic                dbus_req_ready_o,
   output logic                dbus_rsp_valid_o,
   output soc_bus_pkg::data_t  dbus_rdata_o,
   output soc_bus_pkg::data_t  gpio_o
);
   import soc_bus_pkg::*;

   // data port, sram branch
   logic      mem_req_valid;
   addr_t     mem_addr;
   data_t     mem_wdata;
   strb_t     mem_wstrb;
   logic      mem_req_ready;
   logic      mem_rsp_valid;
   data_t     mem_rdata;

   // data port, peripheral branch
   logic      per_req_valid;
   addr_t     per_addr;
   data_t     per_wdata;
   strb_t     per_wstrb;
   logic      per_req_ready;
   logic      per_rsp_valid;
   data_t     per_rdata;

   // arbiter to sram
   logic      sram_req_valid;
   sram_idx_t sram_idx;
   data_t     sram_wdata;
   strb_t     sram_wstrb;
   logic      sram_rsp_valid;
   data_t     sram_rdata;

   data_bus_split data_bus_split_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .m_req_valid_i  (dbus_req_valid_i),
      .m_addr_i       (dbus_addr_i),
      .m_wdata_i      (dbus_wdata_i),
      .m_wstrb_i      (dbus_wstrb_i),
      .m_req_ready_o  (dbus_req_ready_o),
      .m_rsp_valid_o  (dbus_rsp_valid_o),
      .m_rdata_o      (dbus_rdata_o),
      .mem_req_valid_o(mem_req_valid),
      .mem_addr_o     (mem_addr),
      .mem_wdata_o    (mem_wdata),
      .mem_wstrb_o    (mem_wstrb),
      .mem_req_ready_i(mem_req_ready),
      .mem_rsp_valid_i(mem_rsp_valid),
      .mem_rdata_i    (mem_rdata),
      .per_req_valid_o(per_req_valid),
      .per_addr_o     (per_addr),
      .per_wdata_o    (per_wdata),
      .per_wstrb_o    (per_wstrb),
      .per_req_ready_i(per_req_ready),
      .per_rsp_valid_i(per_rsp_valid),
      .per_rdata_i    (per_rdata)
   );

   sram_arbiter sram_arbiter_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .i_req_valid_i(ibus_req_valid_i),
      .i_addr_i     (ibus_addr_i),
      .i_req_ready_o(ibus_req_ready_o),
      .i_rsp_valid_o(ibus_rsp_valid_o),
      .i_rdata_o    (ibus_rdata_o),
      .d_req_valid_i(mem_req_valid),
      .d_addr_i     (mem_addr),
      .d_wdata_i    (mem_wdata),
      .d_wstrb_i    (mem_wstrb),
      .d_req_ready_o(mem_req_ready),
      .d_rsp_valid_o(mem_rsp_valid),
      .d_rdata_o    (mem_rdata),
      .s_req_valid_o(sram_req_valid),
      .s_idx_o      (sram_idx),
      .s_wdata_o    (sram_wdata),
      .s_wstrb_o    (sram_wstrb),
      .s_rsp_valid_i(sram_rsp_valid),
      .s_rdata_i    (sram_rdata)
   );

   int_sram int_sram_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_valid_i(sram_req_valid),
      .idx_i      (sram_idx),
      .wdata_i    (sram_wdata),
      .wstrb_i    (sram_wstrb),
      .rsp_valid_o(sram_rsp_valid),
      .rdata_o    (sram_rdata)
   );

   periph_regs periph_regs_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_valid_i(per_req_valid),
      .addr_i     (per_addr),
      .wdata_i    (per_wdata),
      .wstrb_i    (per_wstrb),
      .req_ready_o(per_req_ready),
      .rsp_valid_o(per_rsp_valid),
      .rdata_o    (per_rdata),
      .gpio_o     (gpio_o)
   );

endmodule

/* rtl/sram_arbiter.sv */
`timescale 1ns/1ps

module sram_arbiter (
   input  logic                    clk_i,
   input  logic                    rst_i,
   // instruction port, read only
   input  logic                    i_req_valid_i,
   input  soc_bus_pkg::addr_t      i_addr_i,
   output logic                    i_req_ready_o,
   output logic                    i_rsp_valid_o,
   output soc_bus_pkg::data_t      i_rdata_o,
   // data port
   input  logic                    d_req_valid_i,
   input  soc_bus_pkg::addr_t      d_addr_i,
   input  soc_bus_pkg::data_t      d_wdata_i,
   input  soc_bus_pkg::strb_t      d_wstrb_i,
   output logic                    d_req_ready_o,
   output logic                    d_rsp_valid_o,
   output soc_bus_pkg::data_t      d_rdata_o,
   // sram link
   output logic                    s_req_valid_o,
   output soc_bus_pkg::sram_idx_t  s_idx_o,
   output soc_bus_pkg::data_t      s_wdata_o,
   output soc_bus_pkg::strb_t      s_wstrb_o,
   input  logic                    s_rsp_valid_i,
   input  soc_bus_pkg::data_t      s_rdata_i
);
   import soc_bus_pkg::*;

   typedef enum logic [1:0] {
      idle,
      wait_i,
      wait_d
   } arb_state_t;

   arb_state_t state_q;
   logic       live_q;
   logic       last_d_q;
   logic       free;
   logic       gnt_i;
   logic       gnt_d;

   assign free = live_q & (state_q == idle);

   // on contention the port not served last wins
   assign gnt_i = free & i_req_valid_i & (~d_req_valid_i | last_d_q);
   assign gnt_d = free & d_req_valid_i & (~i_req_valid_i | ~last_d_q);

   assign i_req_ready_o = gnt_i;
   assign d_req_ready_o = gnt_d;

   // byte address to word index
   assign s_req_valid_o = gnt_i | gnt_d;
   assign s_idx_o       = gnt_d ? d_addr_i[WORD_LSB +: SRAM_ADDR_W]
                                : i_addr_i[WORD_LSB +: SRAM_ADDR_W];
   assign s_wdata_o     = d_wdata_i;
   assign s_wstrb_o     = gnt_d ? d_wstrb_i : '0;

   // response goes back only to the owner
   assign i_rsp_valid_o = s_rsp_valid_i & (state_q == wait_i);
   assign d_rsp_valid_o = s_rsp_valid_i & (state_q == wait_d);
   assign i_rdata_o     = s_rdata_i;
   assign d_rdata_o     = s_rdata_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q  <= idle;
         live_q   <= 1'b0;
         last_d_q <= 1'b0;
      end else begin
         live_q <= 1'b1;
         case (state_q)
            idle: begin
               if (gnt_i) begin
                  state_q  <= wait_i;
                  last_d_q <= 1'b0;
               end else if (gnt_d) begin
                  state_q  <= wait_d;
                  last_d_q <= 1'b1;
               end
            end
            wait_i, wait_d: begin
               if (s_rsp_valid_i) begin
                  state_q <= idle;
               end
            end
            default: state_q <= idle;
         endcase
      end
   end

   // a port that lost to the other gets the next grant
   a_rr_turn_i: assert property (
      @(posedge clk_i) disable iff (rst_i) $past(gnt_d && i_req_valid_i, 2) |-> gnt_i);
   a_rr_turn_d: assert property (
      @(posedge clk_i) disable iff (rst_i) $past(gnt_i && d_req_valid_i, 2) |-> gnt_d);
   // sram answers exactly one cycle later, and only while someone waits
   a_sram_latency: assert property (
      @(posedge clk_i) disable iff (rst_i) s_req_valid_o |=> s_rsp_valid_i);
   a_rsp_in_wait: assert property (
      @(posedge clk_i) disable iff (rst_i) s_rsp_valid_i |-> state_q != idle);

endmodule

/* sim/soc_trace.txt */
# phase port(I/D) addr wdata wstrb expect, all hex except phase
# expect is the read data; for a data-port write it is gpio_o at the write's response
0 D 8000 00000000 0 00000000
0 D 8004 00000000 0 00000000
1 D 0000 11223344 f 00000000
1 D 0004 55667788 f 00000000
1 D 0008 99aabbcc f 00000000
1 D 000c deadbeef f 00000000
1 D 0010 01020304 f 00000000
1 D 0100 13579bdf f 00000000
2 D 0000 ffffffff 1 00000000
2 D 8000 000000a5 f 000000a5
2 D 0004 aabbccdd 6 000000a5
2 D 8000 0000ff00 2 0000ffa5
2 D 0008 00000000 8 0000ffa5
2 D 8004 feedface f 0000ffa5
2 D 000c 12345678 3 0000ffa5
2 D 8008 ffffffff f 0000ffa5
2 D 8100 77777777 f 0000ffa5
2 I 0010 00000000 0 01020304
2 I 0100 00000000 0 13579bdf
2 I 0010 00000000 0 01020304
3 D 0000 00000000 0 112233ff
3 D 0004 00000000 0 55bbcc88
3 D 0008 00000000 0 00aabbcc
3 D 000c 00000000 0 dead5678
3 D 0100 00000000 0 13579bdf
3 D 8000 00000000 0 0000ffa5
3 D 8004 00000000 0 feedface
3 D 8008 00000000 0 50c00001
3 D 800c 00000000 0 00000000
3 D 8100 00000000 0 00000000
3 I 0000 00000000 0 112233ff
3 I 0004 00000000 0 55bbcc88
3 I 0008 00000000 0 00aabbcc
3 I 000c 00000000 0 dead5678
4 D 0200 a0a1a2a3 f 0000ffa5
4 D 8000 3c000000 8 3c00ffa5
4 D 8004 00001111 3 3c00ffa5
4 D 0204 b0b1b2b3 f 3c00ffa5
4 I 0010 00000000 0 01020304
4 I 0100 00000000 0 13579bdf
4 I 000c 00000000 0 dead5678
5 D 0204 00000000 0 b0b1b2b3
5 D 8000 00000000 0 3c00ffa5
5 D 8004 00000000 0 feed1111
5 I 0200 00000000 0 a0a1a2a3

/* sim/tb_soc_bus_top.sv */
`timescale 1ns/1ps

module tb_soc_bus_top;
   import soc_bus_pkg::*;

   logic  clk_i;
   logic  rst_i;
   logic  ibus_req_valid_i;
   addr_t ibus_addr_i;
   logic  ibus_req_ready_o;
   logic  ibus_rsp_valid_o;
   data_t ibus_rdata_o;
   logic  dbus_req_valid_i;
   addr_t dbus_addr_i;
   data_t dbus_wdata_i;
   strb_t dbus_wstrb_i;
   logic  dbus_req_ready_o;
   logic  dbus_rsp_valid_o;
   data_t dbus_rdata_o;
   data_t gpio_o;

   // one entry per trace line
   int    tr_phase[$];
   logic  tr_is_d[$];
   addr_t tr_addr[$];
   data_t tr_wdata[$];
   strb_t tr_wstrb[$];
   data_t tr_exp[$];

   int    error_count;
   int    check_count;
   int    cycle_count;
   int    cycle_limit;
   logic  i_waiting;
   logic  d_waiting;

   soc_bus_top soc_bus_top_i (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .ibus_req_valid_i(ibus_req_valid_i),
      .ibus_addr_i     (ibus_addr_i),
      .ibus_req_ready_o(ibus_req_ready_o),
      .ibus_rsp_valid_o(ibus_rsp_valid_o),
      .ibus_rdata_o    (ibus_rdata_o),
      .dbus_req_valid_i(dbus_req_valid_i),
      .dbus_addr_i     (dbus_addr_i),
      .dbus_wdata_i    (dbus_wdata_i),
      .dbus_wstrb_i    (dbus_wstrb_i),
      .dbus_req_ready_o(dbus_req_ready_o),
      .dbus_rsp_valid_o(dbus_rsp_valid_o),
      .dbus_rdata_o    (dbus_rdata_o),
      .gpio_o          (gpio_o)
   );

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, an access never completed", cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   // a response with nothing outstanding is lost or misrouted
   always @(negedge clk_i) begin
      if (!rst_i && ibus_rsp_valid_o && !i_waiting) begin
         $display("instruction port gave a response with no request outstanding");
         error_count++;
      end
      if (!rst_i && dbus_rsp_valid_o && !d_waiting) begin
         $display("data port gave a response with no request outstanding");
         error_count++;
      end
   end

   task automatic check_value(input string name, input data_t got, input data_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic load_trace(output bit ok);
      int         fd;
      int         cnt;
      string      line;
      int         ph;
      logic [7:0] port;
      addr_t      a;
      data_t      wd;
      strb_t      ws;
      data_t      ex;
      ok = 1'b0;
      fd = $fopen("sim/soc_trace.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               cnt = $sscanf(line, "%d %s %h %h %h %h", ph, port, a, wd, ws, ex);
               if (cnt == 6 && (port == "I" || port == "D")) begin
                  tr_phase.push_back(ph);
                  tr_is_d.push_back(port == "D");
                  tr_addr.push_back(a);
                  tr_wdata.push_back(wd);
                  tr_wstrb.push_back(ws);
                  tr_exp.push_back(ex);
               end else begin
                  $display("trace line could not be parsed: %s", line);
                  ok = 1'b0;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // 0 to 3 idle cycles, ends 1 ns after a rising edge
   task automatic idle_cycles();
      int n;
      n = $urandom % 4;
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic run_ibus(input int phase);
      for (int k = 0; k < tr_phase.size(); k++) begin
         if (tr_phase[k] == phase && !tr_is_d[k]) begin
            idle_cycles();
            ibus_addr_i      = tr_addr[k];
            ibus_req_valid_i = 1'b1;
            i_waiting        = 1'b1;
            @(negedge clk_i);
            while (!ibus_req_ready_o) begin
               @(negedge clk_i);
            end
            @(posedge clk_i);
            #1;
            ibus_req_valid_i = 1'b0;
            @(negedge clk_i);
            while (!ibus_rsp_valid_o) begin
               @(negedge clk_i);
            end
            check_value($sformatf("ibus_rdata_o[%h]", tr_addr[k]), ibus_rdata_o, tr_exp[k]);
            @(posedge clk_i);
            #1;
            i_waiting = 1'b0;
         end
      end
   endtask

   task automatic run_dbus(input int phase);
      for (int k = 0; k < tr_phase.size(); k++) begin
         if (tr_phase[k] == phase && tr_is_d[k]) begin
            idle_cycles();
            dbus_addr_i      = tr_addr[k];
            dbus_wdata_i     = tr_wdata[k];
            dbus_wstrb_i     = tr_wstrb[k];
            dbus_req_valid_i = 1'b1;
            d_waiting        = 1'b1;
            @(negedge clk_i);
            while (!dbus_req_ready_o) begin
               @(negedge clk_i);
            end
            @(posedge clk_i);
            #1;
            dbus_req_valid_i = 1'b0;
            @(negedge clk_i);
            while (!dbus_rsp_valid_o) begin
               @(negedge clk_i);
            end
            // on a write the expected column holds gpio_o instead
            if (tr_wstrb[k] == '0) begin
               check_value($sformatf("dbus_rdata_o[%h]", tr_addr[k]), dbus_rdata_o, tr_exp[k]);
            end else begin
               check_value($sformatf("gpio_o[%h]", tr_addr[k]), gpio_o, tr_exp[k]);
            end
            @(posedge clk_i);
            #1;
            d_waiting = 1'b0;
         end
      end
   endtask

   initial begin
      bit ok;
      int last_phase;
      clk_i            = 1'b0;
      rst_i            = 1'b1;
      ibus_req_valid_i = 1'b0;
      ibus_addr_i      = '0;
      dbus_req_valid_i = 1'b0;
      dbus_addr_i      = '0;
      dbus_wdata_i     = '0;
      dbus_wstrb_i     = '0;
      error_count      = 0;
      check_count      = 0;
      cycle_count      = 0;
      cycle_limit      = 0;
      i_waiting        = 1'b0;
      d_waiting        = 1'b0;
      last_phase       = 0;
      void'($urandom(32'h89a2eb25));
      load_trace(ok);
      if (!ok) begin
         $display("trace file sim/soc_trace.txt is missing or malformed");
         $display("Test failures found");
         $finish;
      end else begin
         // worst case per access, random idle plus arbitration wait
         cycle_limit = 40 * tr_phase.size() + 100;
         repeat (8) @(posedge clk_i);
         #1;
         rst_i = 1'b0;
         @(negedge clk_i);
         check_value("gpio_o", gpio_o, '0);
         @(posedge clk_i);
         #1;
         foreach (tr_phase[k]) begin
            if (tr_phase[k] > last_phase) begin
               last_phase = tr_phase[k];
            end
         end
         // a phase starts only once both ports are done with the last one
         for (int p = 0; p <= last_phase; p++) begin
            fork
               run_ibus(p);
               run_dbus(p);
            join
         end
         repeat (2) @(posedge clk_i);
         $display("checks run: %0d, errors: %0d", check_count, error_count);
         if (error_count == 0) begin
            $display("All tests passed!");
         end else begin
            $display("Test failures found");
         end
         $finish;
      end
   end

endmodule
